//--- include/conv3x3_settings.svh
`ifndef CONV3X3_SETTINGS_SVH
`define CONV3X3_SETTINGS_SVH

// image size in pixels.
`define IMG_H 28
`define IMG_W 28

// data widths.
`define PIX_BITS 8
`define COEF_BITS 8

// nine products of 255*255 need 20 bits.
`define ACC_BITS 20

// address and window position widths.
`define ADDR_BITS 10
`define POS_BITS 5

`endif

//--- rtl/conv3x3_pkg.sv
`include "conv3x3_settings.svh"

package conv3x3_pkg;

    typedef logic [`PIX_BITS-1:0]  pixel_t;
    typedef logic [`COEF_BITS-1:0] coef_t;
    typedef logic [`ADDR_BITS-1:0] pix_addr_t;
    typedef logic [`ACC_BITS-1:0]  acc_t;
    typedef logic [1:0]            row_sel_t;

    // fields are named by kernel row and column.
    typedef struct packed {
        coef_t k00, k01, k02;
        coef_t k10, k11, k12;
        coef_t k20, k21, k22;
    } kernel_t;

    typedef struct packed {
        pixel_t p00, p01, p02;
        pixel_t p10, p11, p12;
        pixel_t p20, p21, p22;
    } patch_t;

    // top-left corner of a window.
    typedef struct packed {
        logic [`POS_BITS-1:0] row;
        logic [`POS_BITS-1:0] col;
    } pos_t;

    typedef struct packed {
        pos_t pos;
        acc_t value;
    } result_t;

endpackage

//--- rtl/conv_control.sv
`timescale 1ns/1ps

module conv_control
    import conv3x3_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     start,
    input  logic     last,
    output logic     patch_load,
    output logic     acc_clear,
    output logic     acc_en,
    output row_sel_t row_sel,
    output logic     advance,
    output logic     out_valid,
    output logic     done,
    output logic     busy
);

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        MAC,
        STORE
    } state_t;

    localparam row_sel_t LAST_ROW = 2'd2;

    state_t   state;
    state_t   state_next;
    row_sel_t row_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IDLE;
            row_cnt <= '0;
        end else begin
            state <= state_next;
            // the row counter only runs while in MAC.
            if (state == MAC && row_cnt != LAST_ROW) begin
                row_cnt <= row_cnt + 2'd1;
            end else begin
                row_cnt <= '0;
            end
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (start) begin
                    state_next = LOAD;
                end
            end
            LOAD: begin
                state_next = MAC;
            end
            MAC: begin
                if (row_cnt == LAST_ROW) begin
                    state_next = STORE;
                end
            end
            STORE: begin
                // after the bottom-right window the frame is finished.
                state_next = last ? IDLE : LOAD;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    assign patch_load = (state == LOAD);
    assign acc_clear  = (state == LOAD);
    assign acc_en     = (state == MAC);
    assign row_sel    = row_cnt;
    assign advance    = (state == STORE);
    assign out_valid  = (state == STORE);
    assign done       = (state == STORE) && last;
    assign busy       = (state != IDLE);

endmodule

//--- rtl/window_counters.sv
`timescale 1ns/1ps
`include "conv3x3_settings.svh"

module window_counters
    import conv3x3_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic advance,
    output pos_t pos,
    output logic last
);

    // largest valid top-left corner in each direction.
    localparam logic [`POS_BITS-1:0] LAST_ROW = `POS_BITS'(`IMG_H - 3);
    localparam logic [`POS_BITS-1:0] LAST_COL = `POS_BITS'(`IMG_W - 3);

    logic row_end;
    logic col_end;

    assign row_end = (pos.row == LAST_ROW);
    assign col_end = (pos.col == LAST_COL);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pos <= '0;
        end else if (advance) begin
            if (col_end) begin
                pos.col <= '0;
                // row wraps too once the last window has been stored.
                pos.row <= row_end ? '0 : pos.row + 1'b1;
            end else begin
                pos.col <= pos.col + 1'b1;
            end
        end
    end

    assign last = row_end && col_end;

endmodule

//--- rtl/patch_fetch.sv
`timescale 1ns/1ps
`include "conv3x3_settings.svh"

module patch_fetch
    import conv3x3_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      pix_wr,
    input  pix_addr_t pix_wr_addr,
    input  pixel_t    pix_wr_data,
    input  pos_t      pos,
    input  logic      patch_load,
    output patch_t    patch
);

    localparam int unsigned DEPTH = `IMG_H * `IMG_W;

    // image stored row after row, address = row * IMG_W + col.
    pixel_t    img_mem [DEPTH];

    pix_addr_t base_addr;
    pix_addr_t row1_addr;
    pix_addr_t row2_addr;
    pix_addr_t addr00, addr01, addr02;
    pix_addr_t addr10, addr11, addr12;
    pix_addr_t addr20, addr21, addr22;
    patch_t    patch_q;

    always_ff @(posedge clk) begin
        if (pix_wr) begin
            img_mem[pix_wr_addr] <= pix_wr_data;
        end
    end

    always_comb begin
        base_addr = pix_addr_t'(pos.row) * pix_addr_t'(`IMG_W) + pix_addr_t'(pos.col);
        row1_addr = base_addr + pix_addr_t'(`IMG_W);
        row2_addr = base_addr + pix_addr_t'(2 * `IMG_W);
    end

    // nine addresses of the window, three per image row.
    always_comb begin
        addr00 = base_addr;
        addr01 = base_addr + pix_addr_t'(1);
        addr02 = base_addr + pix_addr_t'(2);
        addr10 = row1_addr;
        addr11 = row1_addr + pix_addr_t'(1);
        addr12 = row1_addr + pix_addr_t'(2);
        addr20 = row2_addr;
        addr21 = row2_addr + pix_addr_t'(1);
        addr22 = row2_addr + pix_addr_t'(2);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            patch_q <= '0;
        end else if (patch_load) begin
            patch_q.p00 <= img_mem[addr00];
            patch_q.p01 <= img_mem[addr01];
            patch_q.p02 <= img_mem[addr02];
            patch_q.p10 <= img_mem[addr10];
            patch_q.p11 <= img_mem[addr11];
            patch_q.p12 <= img_mem[addr12];
            patch_q.p20 <= img_mem[addr20];
            patch_q.p21 <= img_mem[addr21];
            patch_q.p22 <= img_mem[addr22];
        end
    end

    assign patch = patch_q;

endmodule

//--- rtl/mac_array.sv
`timescale 1ns/1ps

module mac_array
    import conv3x3_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     kernel_load,
    input  kernel_t  kernel_in,
    input  patch_t   patch,
    input  row_sel_t row_sel,
    input  logic     acc_en,
    input  logic     acc_clear,
    output acc_t     acc
);

    kernel_t kernel_q;
    acc_t    acc_q;
    pixel_t  pix_row  [3];
    coef_t   coef_row [3];
    acc_t    prod     [3];
    acc_t    row_sum;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            kernel_q <= '0;
        end else if (kernel_load) begin
            kernel_q <= kernel_in;
        end
    end

    // pick the patch row and the kernel row for this MAC cycle.
    always_comb begin
        case (row_sel)
            2'd0: begin
                pix_row  = '{patch.p00, patch.p01, patch.p02};
                coef_row = '{kernel_q.k00, kernel_q.k01, kernel_q.k02};
            end
            2'd1: begin
                pix_row  = '{patch.p10, patch.p11, patch.p12};
                coef_row = '{kernel_q.k10, kernel_q.k11, kernel_q.k12};
            end
            default: begin
                pix_row  = '{patch.p20, patch.p21, patch.p22};
                coef_row = '{kernel_q.k20, kernel_q.k21, kernel_q.k22};
            end
        endcase
    end

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            prod[i] = acc_t'(pix_row[i]) * acc_t'(coef_row[i]);
        end
        row_sum = prod[0] + prod[1] + prod[2];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_q <= '0;
        end else if (acc_clear) begin
            acc_q <= '0;
        end else if (acc_en) begin
            acc_q <= acc_q + row_sum;
        end
    end

    assign acc = acc_q;

endmodule

//--- rtl/conv3x3_top.sv
`timescale 1ns/1ps

module conv3x3_top
    import conv3x3_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      pix_wr,
    input  pix_addr_t pix_wr_addr,
    input  pixel_t    pix_wr_data,
    input  logic      kernel_load,
    input  kernel_t   kernel_in,
    input  logic      start,
    output logic      busy,
    output result_t   out,
    output logic      out_valid,
    output logic      done
);

    logic     patch_load;
    logic     acc_clear;
    logic     acc_en;
    logic     advance;
    logic     last;
    row_sel_t row_sel;
    pos_t     pos;
    patch_t   patch;
    acc_t     acc;

    conv_control u_control (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .last       (last),
        .patch_load (patch_load),
        .acc_clear  (acc_clear),
        .acc_en     (acc_en),
        .row_sel    (row_sel),
        .advance    (advance),
        .out_valid  (out_valid),
        .done       (done),
        .busy       (busy)
    );

    window_counters u_counters (
        .clk     (clk),
        .rst_n   (rst_n),
        .advance (advance),
        .pos     (pos),
        .last    (last)
    );

    patch_fetch u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .pix_wr      (pix_wr),
        .pix_wr_addr (pix_wr_addr),
        .pix_wr_data (pix_wr_data),
        .pos         (pos),
        .patch_load  (patch_load),
        .patch       (patch)
    );

    mac_array u_mac (
        .clk         (clk),
        .rst_n       (rst_n),
        .kernel_load (kernel_load),
        .kernel_in   (kernel_in),
        .patch       (patch),
        .row_sel     (row_sel),
        .acc_en      (acc_en),
        .acc_clear   (acc_clear),
        .acc         (acc)
    );

    // pos still names the current window during STORE.
    assign out.pos   = pos;
    assign out.value = acc;

endmodule

//--- dv/conv3x3_tb.sv
`timescale 1ns/1ps
`include "conv3x3_settings.svh"

module conv3x3_tb
    import conv3x3_pkg::*;
;

    localparam int PIXELS       = `IMG_H * `IMG_W;
    localparam int WIN_ROWS     = `IMG_H - 2;
    localparam int WIN_COLS     = `IMG_W - 2;
    localparam int WINDOWS      = WIN_ROWS * WIN_COLS;
    localparam int FRAME_CYCLES = WINDOWS * 5;
    // three frames and three image loads, with about 60 percent margin.
    localparam int MAX_CYCLES   = 3 * (FRAME_CYCLES + PIXELS) * 8 / 5;

    localparam logic [15:0] LFSR_SEED = 16'd24870;
    localparam logic [15:0] LFSR_TAPS = 16'hB400;

    logic      clk;
    logic      rst_n;
    logic      pix_wr;
    pix_addr_t pix_wr_addr;
    pixel_t    pix_wr_data;
    logic      kernel_load;
    kernel_t   kernel_in;
    logic      start;
    logic      busy;
    result_t   result;
    logic      out_valid;
    logic      done;

    pixel_t      img  [PIXELS];
    coef_t       kern [9];
    logic [15:0] lfsr_state;
    string       test_name;
    int          cycle;

    // state shared between the stimulus and the monitor.
    logic frame_active;
    logic frame_finished;
    logic done_seen;
    int   start_cycle;
    int   next_valid_cycle;
    int   win_idx;
    int   exp_row;
    int   exp_col;

    conv3x3_top DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .pix_wr      (pix_wr),
        .pix_wr_addr (pix_wr_addr),
        .pix_wr_data (pix_wr_data),
        .kernel_load (kernel_load),
        .kernel_in   (kernel_in),
        .start       (start),
        .busy        (busy),
        .out         (result),
        .out_valid   (out_valid),
        .done        (done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // one LFSR step per bit taken.
    function automatic logic [7:0] random_byte();
        logic [7:0] value;
        value = '0;
        for (int i = 0; i < 8; i++) begin
            value = {value[6:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return value;
    endfunction

    // full-width sum, so a result width that is too narrow can be seen.
    function automatic int expected_sum(int row, int col);
        int sum;
        sum = 0;
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 3; c++) begin
                sum += int'(img[(row + r) * `IMG_W + col + c]) * int'(kern[r * 3 + c]);
            end
        end
        return sum;
    endfunction

    function automatic kernel_t pack_kernel();
        kernel_t k;
        k.k00 = kern[0];
        k.k01 = kern[1];
        k.k02 = kern[2];
        k.k10 = kern[3];
        k.k11 = kern[4];
        k.k12 = kern[5];
        k.k20 = kern[6];
        k.k21 = kern[7];
        k.k22 = kern[8];
        return k;
    endfunction

    task automatic fail_run(string reason);
        $display("STATUS: FAIL");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_result(string what, result_t exp, result_t act);
        if (exp !== act) begin
            $display("ERROR %s: %s expected (%0d,%0d) %0d, actual (%0d,%0d) %0d",
                     test_name, what, exp.pos.row, exp.pos.col, exp.value,
                     act.pos.row, act.pos.col, act.value);
            fail_run("result mismatch");
        end
    endtask

    task automatic check_count(string what, int exp, int act);
        if (exp != act) begin
            $display("ERROR %s: %s expected %0d, actual %0d", test_name, what, exp, act);
            fail_run("count mismatch");
        end
    endtask

    task automatic check_flag(string what, logic exp, logic act);
        if (exp !== act) begin
            $display("ERROR %s: %s expected %b, actual %b", test_name, what, exp, act);
            fail_run("flag mismatch");
        end
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            fail_run("timeout: the run did not finish within the cycle limit");
        end
    end

    // monitor: results must arrive every five cycles in raster order.
    always @(posedge clk) begin
        logic    exp_valid;
        int      exp_sum;
        result_t exp;
        if (rst_n && frame_active && !frame_finished) begin
            if (done_seen) begin
                check_flag("busy after done", 1'b0, busy);
                frame_finished = 1'b1;
            end else begin
                exp_valid = (cycle == next_valid_cycle);
                if (cycle != start_cycle) begin
                    check_flag("busy during frame", 1'b1, busy);
                end
                check_flag("out_valid", exp_valid, out_valid);
                if (exp_valid) begin
                    exp_sum = expected_sum(exp_row, exp_col);
                    check_count("sum within result width", exp_sum, int'(acc_t'(exp_sum)));
                    exp.pos.row = `POS_BITS'(exp_row);
                    exp.pos.col = `POS_BITS'(exp_col);
                    exp.value   = acc_t'(exp_sum);
                    check_result("window result", exp, result);
                    win_idx++;
                    next_valid_cycle += 5;
                    if (exp_col == WIN_COLS - 1) begin
                        exp_col = 0;
                        exp_row++;
                    end else begin
                        exp_col++;
                    end
                    if (win_idx == WINDOWS) begin
                        check_flag("done with last result", 1'b1, done);
                    end
                    // an early done ends the frame with too few results.
                    done_seen = done;
                end else begin
                    check_flag("done without a result", 1'b0, done);
                end
            end
        end else if (rst_n) begin
            check_flag("busy while idle", 1'b0, busy);
            check_flag("out_valid while idle", 1'b0, out_valid);
            check_flag("done while idle", 1'b0, done);
        end
    end

    task automatic load_image(bit all_max);
        for (int a = 0; a < PIXELS; a++) begin
            @(negedge clk);
            img[a]      = all_max ? pixel_t'(8'hFF) : random_byte();
            pix_wr      = 1'b1;
            pix_wr_addr = pix_addr_t'(a);
            pix_wr_data = img[a];
        end
        @(negedge clk);
        pix_wr = 1'b0;
    endtask

    task automatic load_kernel(bit all_max);
        for (int i = 0; i < 9; i++) begin
            kern[i] = all_max ? coef_t'(8'hFF) : random_byte();
        end
        @(negedge clk);
        kernel_in   = pack_kernel();
        kernel_load = 1'b1;
        @(negedge clk);
        kernel_load = 1'b0;
    endtask

    task automatic run_frame();
        @(negedge clk);
        win_idx          = 0;
        exp_row          = 0;
        exp_col          = 0;
        done_seen        = 1'b0;
        frame_finished   = 1'b0;
        start_cycle      = cycle;
        next_valid_cycle = cycle + 5;
        frame_active     = 1'b1;
        start            = 1'b1;
        @(negedge clk);
        start = 1'b0;
        wait (frame_finished);
        @(negedge clk);
        frame_active = 1'b0;
        check_count("result count", WINDOWS, win_idx);
    endtask

    initial begin
        rst_n          = 1'b0;
        pix_wr         = 1'b0;
        pix_wr_addr    = '0;
        pix_wr_data    = '0;
        kernel_load    = 1'b0;
        kernel_in      = '0;
        start          = 1'b0;
        cycle          = 0;
        frame_active   = 1'b0;
        frame_finished = 1'b0;
        done_seen      = 1'b0;
        lfsr_state     = LFSR_SEED;
        test_name      = "reset";
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_name = "idle_after_reset";
        repeat (8) begin
            @(negedge clk);
            check_flag("busy", 1'b0, busy);
            check_flag("out_valid", 1'b0, out_valid);
            check_flag("done", 1'b0, done);
        end

        // every window sums to 9 * 255 * 255 here.
        test_name = "all_max";
        load_image(1'b1);
        load_kernel(1'b1);
        run_frame();

        test_name = "random_frame";
        load_image(1'b0);
        load_kernel(1'b0);
        run_frame();

        // the image from the previous test stays in the buffer.
        test_name = "kernel_reload";
        load_kernel(1'b0);
        run_frame();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- conv3x3.f
+incdir+include
rtl/conv3x3_pkg.sv
rtl/conv_control.sv
rtl/window_counters.sv
rtl/patch_fetch.sv
rtl/mac_array.sv
rtl/conv3x3_top.sv
dv/conv3x3_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the conv3x3 testbench with Verilator and runs it.
# The exit status is the simulator's own, so a failing run fails the script.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    --top-module conv3x3_tb \
    -f conv3x3.f \
    -o sim_conv3x3
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_conv3x3
status=$?
if [ $status -ne 0 ]; then
    echo "simulation ended with status $status"
    exit $status
fi
exit 0
